/* Makefile */
TOOL       = verilator
TOP        = draw_core_tb
FILELIST   = tb.f
FLAGS      = --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
OBJ_DIR    = obj_dir
PASS_MSG   = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* dv/draw_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none
`include "draw_consts.svh"

// Memory handshake and done strobe rules.
module draw_core_assert (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               wr_req,
  input wire logic               wr_done,
  input wire logic [`ADDR_W-1:0] wr_addr,
  input wire logic [`PIX_W-1:0]  wr_data,
  input wire logic               done
);

  // Request holds, address and data frozen, until the memory answers.
  req_held_a : assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_done |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else $error("wr_req dropped or changed before wr_done");

  done_single_a : assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
    else $error("done lasted two cycles");

  req_drop_a : assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && wr_done |=> !wr_req)   // One pixel in flight.
    else $error("wr_req still high after wr_done");

endmodule

bind draw_core draw_core_assert assert_i (
  .clk(clk), .rst_n(rst_n), .wr_req(wr_req), .wr_done(wr_done),
  .wr_addr(wr_addr), .wr_data(wr_data), .done(done)
);

`default_nettype wire

/* dv/draw_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "draw_consts.svh"

module draw_core_tb;

  localparam int CLK_HALF  = 4;        // 8 ns period.
  localparam int DRIVE_DLY = 1;        // Inputs move just after the edge.
  localparam int NUM_ROWS  = 7;
  localparam int NUM_SMP   = 602;      // Two past the ring size to see the wrap.
  localparam int FONT_SIZE = 1 << `FONT_ADDR_W;

  typedef struct {
    draw_pkg::draw_op_e op;
    logic [`COORD_W-1:0] x;
    logic [`COORD_W-1:0] y;
    logic [`COORD_W-1:0] len;
    logic [`PIX_W-1:0]   color;
    logic [2:0]          sel;
    bit                  poke;         // Second start while busy.
  } cmd_row_t;

  logic                clk;
  logic                rst_n;
  logic                start;
  draw_pkg::draw_op_e  cmd;
  logic [`COORD_W-1:0] x;
  logic [`COORD_W-1:0] y;
  logic [`COORD_W-1:0] len;
  logic [`PIX_W-1:0]   color;
  logic [2:0]          glyph;
  logic                font_we;
  logic [`FONT_ADDR_W-1:0] font_addr;
  logic [7:0]          font_data;
  logic                done;
  logic                wr_req;
  logic [`ADDR_W-1:0]  wr_addr;
  logic [`PIX_W-1:0]   wr_data;
  logic                wr_done;

  cmd_row_t    cmd_table [NUM_ROWS];
  logic [7:0]  font_model [FONT_SIZE];   // Copy of what was loaded.
  logic [39:0] exp_q [$];                // {addr, data} in write order.
  logic [39:0] exp_word;
  logic [31:0] rng_state = 32'd36040;
  int          done_count  = 0;
  int          sample_ptr  = 0;
  int          cycle_count = 0;
  int          cycle_limit = 32'h7fff_ffff;
  logic [1:0]  mem_wait;
  bit          mem_busy;

  draw_core dut_i (
    .clk, .rst_n, .start, .cmd, .x, .y, .len, .color, .glyph,
    .font_we, .font_addr, .font_data, .done,
    .wr_req, .wr_addr, .wr_data, .wr_done
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error @ %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model with 0 to 3 wait cycles per write.
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    #DRIVE_DLY;
    if (!rst_n) begin
      wr_done  = 1'b0;
      mem_busy = 1'b0;
    end else if (wr_done) begin
      wr_done = 1'b0;                    // Write taken at this edge.
    end else if (wr_req) begin
      if (!mem_busy) begin
        rng_state = xorshift(rng_state);
        mem_wait  = rng_state[1:0];
        mem_busy  = 1'b1;
      end
      if (mem_wait == 2'd0) begin
        wr_done  = 1'b1;
        mem_busy = 1'b0;
      end else begin
        mem_wait = mem_wait - 2'd1;
      end
    end
  end

  // Done pulses and completed writes are sampled mid-cycle.
  always @(negedge clk) begin
    if (rst_n && done) done_count++;
    if (rst_n && wr_req && wr_done) begin
      if (exp_q.size() == 0) begin
        $display("A memory write to %0h arrived with no write expected", wr_addr);
        $display("Verification failed");
        $fatal(1, "unexpected write");
      end else begin
        exp_word = exp_q.pop_front();
        check_value("wr_addr", 64'(wr_addr), 64'(exp_word[39:16]));
        check_value("wr_data", 64'(wr_data), 64'(exp_word[15:0]));
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout, run went past %0d cycles", cycle_limit);
      $display("Verification failed");
      $fatal(1, "timeout");
    end
  end

  function automatic int pixels_for(input draw_pkg::draw_op_e op,
                                    input logic [`COORD_W-1:0] n);
    case (op)
      draw_pkg::OP_CLEAR: return `FB_PIXELS;
      draw_pkg::OP_HLINE,
      draw_pkg::OP_VLINE: return int'(n);
      draw_pkg::OP_GLYPH: return `GLYPH_DIM * `GLYPH_DIM;
      default:            return 1;
    endcase
  endfunction

  // Expected writes from screen geometry and the font copy.
  task automatic build_expected(input cmd_row_t row);
    int         base;
    int         a;
    logic [7:0] fbyte;
    logic [`PIX_W-1:0] pix;
    base = int'(row.y) * `SCREEN_W + int'(row.x);
    case (row.op)
      draw_pkg::OP_CLEAR:
        for (int i = 0; i < `FB_PIXELS; i++) exp_q.push_back({`ADDR_W'(i), row.color});
      draw_pkg::OP_HLINE:
        for (int i = 0; i < int'(row.len); i++)
          exp_q.push_back({`ADDR_W'(base + i), row.color});
      draw_pkg::OP_VLINE:
        for (int i = 0; i < int'(row.len); i++)
          exp_q.push_back({`ADDR_W'(base + i * `SCREEN_W), row.color});
      draw_pkg::OP_GLYPH: begin
        for (int c = 0; c < `GLYPH_DIM; c++) begin
          for (int r = 0; r < `GLYPH_DIM; r++) begin
            fbyte = font_model[int'(row.sel) * 128 + c * 4 + r / 8];
            a     = (int'(row.y) + c) * `SCREEN_W + int'(row.x) - 1 - r;
            pix   = fbyte[r % 8] ? row.color : `COLOR_BLACK;   // Clear bit is black.
            exp_q.push_back({`ADDR_W'(a), pix});
          end
        end
      end
      default: begin                     // Sample ring wraps at depth.
        exp_q.push_back({`ADDR_W'(`SAMPLE_BASE + sample_ptr), row.color});
        sample_ptr = (sample_ptr + 1) % `SAMPLE_DEPTH;
      end
    endcase
  endtask

  task automatic run_command(input cmd_row_t row);
    int base_done;
    build_expected(row);
    base_done = done_count;
    @(posedge clk);
    #DRIVE_DLY;
    cmd   = row.op;
    x     = row.x;
    y     = row.y;
    len   = row.len;
    color = row.color;
    glyph = row.sel;
    start = 1'b1;
    @(posedge clk);
    #DRIVE_DLY start = 1'b0;
    if (row.poke) begin
      repeat (3) @(posedge clk);
      #DRIVE_DLY;
      cmd   = draw_pkg::OP_HLINE;        // Must be dropped by a busy engine.
      x     = 10'd0;
      y     = 10'd0;
      len   = 10'd5;
      color = 16'hffff;
      start = 1'b1;
      @(posedge clk);
      #DRIVE_DLY start = 1'b0;
    end
    wait (done_count != base_done);
    check_value("writes left at done", 64'(exp_q.size()), 64'd0);
    repeat (6) @(posedge clk);           // A second done would land here.
    check_value("done count", 64'(done_count), 64'(base_done + 1));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence.
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    int       total;
    cmd_row_t smp;
    rst_n     = 1'b0;
    start     = 1'b0;
    cmd       = draw_pkg::OP_CLEAR;
    x         = '0;
    y         = '0;
    len       = '0;
    color     = '0;
    glyph     = '0;
    font_we   = 1'b0;
    font_addr = '0;
    font_data = '0;
    wr_done   = 1'b0;
    cmd_table[0] = '{draw_pkg::OP_CLEAR, 10'd0,   10'd0,   10'd0,   16'h1234, 3'd0, 1'b0};
    cmd_table[1] = '{draw_pkg::OP_HLINE, 10'd10,  10'd20,  10'd100, 16'ha5a5, 3'd0, 1'b1};
    cmd_table[2] = '{draw_pkg::OP_VLINE, 10'd479, 10'd0,   10'd800, 16'h5a5a, 3'd0, 1'b0};
    cmd_table[3] = '{draw_pkg::OP_HLINE, 10'd0,   10'd799, 10'd480, 16'hc3c3, 3'd0, 1'b0};
    cmd_table[4] = '{draw_pkg::OP_VLINE, 10'd100, 10'd300, 10'd37,  16'h0f0f, 3'd0, 1'b1};
    cmd_table[5] = '{draw_pkg::OP_GLYPH, 10'd40,  10'd50,  10'd0,   16'hf800, 3'd3, 1'b0};
    cmd_table[6] = '{draw_pkg::OP_GLYPH, 10'd300, 10'd700, 10'd0,   16'h07e0, 3'd7, 1'b0};

    // Worst case is 6 cycles per pixel with 3 wait cycles.
    total = NUM_SMP;
    for (int i = 0; i < NUM_ROWS; i++) total += pixels_for(cmd_table[i].op, cmd_table[i].len);
    cycle_limit = total * 7 + FONT_SIZE + (NUM_ROWS + NUM_SMP) * 64 + 1000;

    repeat (2) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;

    for (int i = 0; i < FONT_SIZE; i++) begin   // Load one random font byte per cycle.
      rng_state     = xorshift(rng_state);
      font_model[i] = rng_state[7:0];
      @(posedge clk);
      #DRIVE_DLY;
      font_we   = 1'b1;
      font_addr = `FONT_ADDR_W'(i);
      font_data = rng_state[7:0];
    end
    @(posedge clk);
    #DRIVE_DLY font_we = 1'b0;

    for (int i = 0; i < NUM_ROWS; i++) run_command(cmd_table[i]);

    for (int i = 0; i < NUM_SMP; i++) begin
      rng_state = xorshift(rng_state);
      smp = '{draw_pkg::OP_SAMPLE, 10'd0, 10'd0, 10'd0, rng_state[15:0], 3'd0, 1'b0};
      run_command(smp);
    end

    check_value("writes left at end", 64'(exp_q.size()), 64'd0);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* src/cmd_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "draw_consts.svh"

module cmd_regs (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           start,
  input  wire draw_pkg::draw_op_e             cmd,
  input  wire logic [`COORD_W-1:0]            x,
  input  wire logic [`COORD_W-1:0]            y,
  input  wire logic [`COORD_W-1:0]            len,
  input  wire draw_pkg::pixel_t               color,
  input  wire logic [$clog2(`GLYPH_COUNT)-1:0] glyph,
  input  wire logic                           span_fin,
  input  wire logic                           glyph_fin,
  output logic                                done,
  output logic                                go_span,
  output logic                                go_glyph,
  output draw_pkg::addr_t                     span_base,
  output draw_pkg::addr_t                     span_step,
  output logic [`ADDR_W-1:0]                  span_count,
  output draw_pkg::pixel_t                    span_color,
  output draw_pkg::addr_t                     glyph_base,
  output logic [$clog2(`GLYPH_COUNT)-1:0]     glyph_sel,
  output draw_pkg::pixel_t                    glyph_color
);

  logic                              busy;
  logic [$clog2(`SAMPLE_DEPTH)-1:0]  smp_ptr;   // Ring write pointer.
  draw_pkg::addr_t                   lin_addr;
  logic                              is_span;
  logic                              is_glyph;
  logic                              accept;

  // Linear address of (x,y), row major.
  assign lin_addr = draw_pkg::addr_t'(y) * draw_pkg::addr_t'(`SCREEN_W)
                  + draw_pkg::addr_t'(x);

  always_comb begin
    is_span  = 1'b0;
    is_glyph = 1'b0;
    case (cmd)
      draw_pkg::OP_CLEAR,
      draw_pkg::OP_HLINE,
      draw_pkg::OP_VLINE,
      draw_pkg::OP_SAMPLE: is_span  = 1'b1;
      draw_pkg::OP_GLYPH:  is_glyph = 1'b1;
      default: ;                             // Unknown opcode, dropped.
    endcase
  end

  assign accept = start && !busy && (is_span || is_glyph);  // Start while busy ignored.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      go_span  <= 1'b0;
      go_glyph <= 1'b0;
      smp_ptr  <= '0;
    end else begin
      go_span  <= accept && is_span;
      go_glyph <= accept && is_glyph;
      done     <= span_fin || glyph_fin;      // One cycle after finish.
      if (accept) begin
        busy <= 1'b1;
      end else if (span_fin || glyph_fin) begin
        busy <= 1'b0;                         // Drops with done.
      end
      // Ring pointer moves once per accepted sample.
      if (accept && cmd == draw_pkg::OP_SAMPLE) begin
        if (smp_ptr == `SAMPLE_DEPTH - 1) smp_ptr <= '0;
        else                              smp_ptr <= smp_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command fields, latched on accept.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (accept) begin
      span_color  <= color;
      glyph_color <= color;
      glyph_sel   <= glyph;
      glyph_base  <= lin_addr - 1'b1;   // Glyph rows grow toward lower x.
      case (cmd)
        draw_pkg::OP_CLEAR: begin
          span_base  <= '0;
          span_step  <= draw_pkg::addr_t'(1);
          span_count <= `ADDR_W'(`FB_PIXELS);
        end
        draw_pkg::OP_HLINE: begin
          span_base  <= lin_addr;
          span_step  <= draw_pkg::addr_t'(1);
          span_count <= `ADDR_W'(len);
        end
        draw_pkg::OP_VLINE: begin
          span_base  <= lin_addr;
          span_step  <= draw_pkg::addr_t'(`SCREEN_W);  // One row down.
          span_count <= `ADDR_W'(len);
        end
        default: begin                                // Sample write.
          span_base  <= draw_pkg::addr_t'(`SAMPLE_BASE) + draw_pkg::addr_t'(smp_ptr);
          span_step  <= draw_pkg::addr_t'(1);
          span_count <= `ADDR_W'(1);
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/draw_consts.svh */
`ifndef DRAW_CONSTS_SVH
`define DRAW_CONSTS_SVH

// Screen geometry, portrait panel.
`define SCREEN_W     480
`define SCREEN_H     800
`define FB_PIXELS    384000   // SCREEN_W * SCREEN_H.

// Memory port widths.
`define ADDR_W       24       // Bank + row + column.
`define PIX_W        16       // RGB565.
`define COORD_W      10

// Glyph bitmaps, 32x32, column major, 4 bytes per column.
`define GLYPH_DIM    32
`define GLYPH_COUNT  8
`define FONT_ADDR_W  10       // 8 glyphs * 128 bytes.

// Sample ring sits right above the framebuffer.
`define SAMPLE_BASE  384000
`define SAMPLE_DEPTH 600

`define COLOR_BLACK  16'h0000

`endif

/* src/draw_core.sv */
`timescale 1ns/1ps
`default_nettype none
`include "draw_consts.svh"

module draw_core (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  // Command.
  input  wire logic                            start,
  input  wire draw_pkg::draw_op_e              cmd,
  input  wire logic [`COORD_W-1:0]             x,
  input  wire logic [`COORD_W-1:0]             y,
  input  wire logic [`COORD_W-1:0]             len,
  input  wire draw_pkg::pixel_t                color,
  input  wire logic [$clog2(`GLYPH_COUNT)-1:0] glyph,
  // Font load.
  input  wire logic                            font_we,
  input  wire logic [`FONT_ADDR_W-1:0]         font_addr,
  input  wire logic [7:0]                      font_data,
  output logic                                 done,
  // Memory write port.
  output logic                                 wr_req,
  output draw_pkg::addr_t                      wr_addr,
  output draw_pkg::pixel_t                     wr_data,
  input  wire logic                            wr_done
);

  logic                              go_span;
  logic                              go_glyph;
  logic                              span_fin;
  logic                              glyph_fin;
  draw_pkg::addr_t                   span_base;
  draw_pkg::addr_t                   span_step;
  logic [`ADDR_W-1:0]                span_count;
  draw_pkg::pixel_t                  span_color;
  draw_pkg::addr_t                   glyph_base;
  logic [$clog2(`GLYPH_COUNT)-1:0]   glyph_sel;
  draw_pkg::pixel_t                  glyph_color;

  pix_if span_pix ();
  pix_if glyph_pix ();

  cmd_regs regs_i (
    .clk, .rst_n, .start, .cmd, .x, .y, .len, .color, .glyph,
    .span_fin, .glyph_fin, .done, .go_span, .go_glyph,
    .span_base, .span_step, .span_count, .span_color,
    .glyph_base, .glyph_sel, .glyph_color
  );

  span_engine span_i (
    .clk, .rst_n, .go(go_span), .base(span_base), .step(span_step),
    .count(span_count), .color(span_color), .fin(span_fin), .pix(span_pix)
  );

  glyph_engine glyph_i (
    .clk, .rst_n, .go(go_glyph), .base(glyph_base), .sel(glyph_sel),
    .color(glyph_color), .font_we, .font_addr, .font_data,
    .fin(glyph_fin), .pix(glyph_pix)
  );

  pixel_writer writer_i (
    .clk, .rst_n, .wr_done, .wr_req, .wr_addr, .wr_data,
    .span_pix, .glyph_pix
  );

endmodule

`default_nettype wire

/* src/draw_pkg.sv */
`default_nettype none
`include "draw_consts.svh"

package draw_pkg;

  // Drawing commands.
  typedef enum logic [2:0] {
    OP_CLEAR  = 3'd0,  // Fill the whole framebuffer.
    OP_HLINE  = 3'd1,
    OP_VLINE  = 3'd2,
    OP_GLYPH  = 3'd3,  // 32x32 bitmap from font RAM.
    OP_SAMPLE = 3'd4   // One value into the sample ring.
  } draw_op_e;

  typedef enum logic [1:0] {
    SP_IDLE,
    SP_ISSUE,  // Pixel on the bus, waiting for ack.
    SP_WAIT    // Gap cycle after ack.
  } span_state_e;

  typedef enum logic [1:0] {
    GL_IDLE,
    GL_FETCH,  // Font byte read.
    GL_ISSUE,
    GL_WAIT
  } glyph_state_e;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`PIX_W-1:0]  pixel_t;

endpackage

`default_nettype wire

/* src/glyph_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "draw_consts.svh"

// Font RAM plus 32x32 bitmap blit.
module glyph_engine (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            go,
  input  wire draw_pkg::addr_t                 base,
  input  wire logic [$clog2(`GLYPH_COUNT)-1:0] sel,
  input  wire draw_pkg::pixel_t                color,
  input  wire logic                            font_we,
  input  wire logic [`FONT_ADDR_W-1:0]         font_addr,
  input  wire logic [7:0]                      font_data,
  output logic                                 fin,
  pix_if.src                                   pix
);

  ////////////////////////////////////////////////////////////////////////////
  // Font storage, 128 bytes per glyph.
  ////////////////////////////////////////////////////////////////////////////
  logic [7:0] font_mem [0:(1 << `FONT_ADDR_W)-1];

  draw_pkg::glyph_state_e state;
  draw_pkg::addr_t        addr;
  logic [$clog2(`GLYPH_DIM * `GLYPH_DIM / 8)-1:0] byte_idx;  // c*4 + r/8.
  logic [2:0]             bit_idx;   // r mod 8.
  logic [7:0]             bits;      // Current byte, LSB is next pixel.
  logic                   col_end;
  logic                   last;

  // Column ends on bit 7 of its fourth byte.
  assign col_end = (&byte_idx[1:0]) && (&bit_idx);
  assign last    = (&byte_idx) && (&bit_idx);

  assign pix.valid = (state == draw_pkg::GL_ISSUE);
  assign pix.addr  = addr;
  assign pix.data  = bits[0] ? color : `COLOR_BLACK;   // Clear bits paint black.

  assign fin = pix.valid && pix.ack && last;

  // Load port and synchronous read into the shift register.
  always_ff @(posedge clk) begin
    if (font_we) begin
      font_mem[font_addr] <= font_data;
    end
    if (state == draw_pkg::GL_FETCH) begin
      bits <= font_mem[{sel, byte_idx}];
    end else if (pix.valid && pix.ack) begin
      bits <= bits >> 1;                  // LSB first.
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Blit FSM, one byte fetch per eight pixels.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= draw_pkg::GL_IDLE;
      addr     <= '0;
      byte_idx <= '0;
      bit_idx  <= '0;
    end else begin
      case (state)
        draw_pkg::GL_IDLE: begin
          if (go) begin
            addr     <= base;           // Column 0, row 0.
            byte_idx <= '0;
            bit_idx  <= '0;
            state    <= draw_pkg::GL_FETCH;
          end
        end
        draw_pkg::GL_FETCH: state <= draw_pkg::GL_ISSUE;
        draw_pkg::GL_ISSUE: begin
          if (pix.ack) begin
            if (last) begin
              state <= draw_pkg::GL_IDLE;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              // Rows walk toward lower x. At column end, jump one line
              // down and back to the first row.
              if (col_end) begin
                addr <= addr + draw_pkg::addr_t'(`SCREEN_W + `GLYPH_DIM - 1);
              end else begin
                addr <= addr - 1'b1;
              end
              if (&bit_idx) begin
                byte_idx <= byte_idx + 1'b1;   // Byte used up.
                state    <= draw_pkg::GL_FETCH;
              end else begin
                state <= draw_pkg::GL_WAIT;
              end
            end
          end
        end
        draw_pkg::GL_WAIT: state <= draw_pkg::GL_ISSUE;  // Gap after ack.
        default: state <= draw_pkg::GL_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/pix_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One pixel request from a draw engine to the memory writer.
interface pix_if;

  logic            valid;  // Held until ack.
  draw_pkg::addr_t addr;
  draw_pkg::pixel_t data;
  logic            ack;    // Single cycle.

  modport src (
    output valid,
    output addr,
    output data,
    input  ack
  );

  modport dst (
    input  valid,
    input  addr,
    input  data,
    output ack
  );

endinterface

`default_nettype wire

/* src/pixel_writer.sv */
`timescale 1ns/1ps
`default_nettype none

// Memory write port, one pixel in flight.
module pixel_writer (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        wr_done,
  output logic             wr_req,
  output draw_pkg::addr_t  wr_addr,
  output draw_pkg::pixel_t wr_data,
  pix_if.dst               span_pix,
  pix_if.dst               glyph_pix
);

  logic from_glyph;   // Owner of the pixel in flight.
  logic take;
  logic fire;

  // Only one engine runs at a time.
  assign take = !wr_req && (span_pix.valid || glyph_pix.valid);
  assign fire = wr_req && wr_done;           // Memory accepted the write.

  assign span_pix.ack  = fire && !from_glyph;
  assign glyph_pix.ack = fire && from_glyph;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_req     <= 1'b0;
      from_glyph <= 1'b0;
    end else if (take) begin
      wr_req     <= 1'b1;                    // Held until wr_done.
      from_glyph <= !span_pix.valid;
    end else if (fire) begin
      wr_req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      wr_addr <= span_pix.valid ? span_pix.addr : glyph_pix.addr;
      wr_data <= span_pix.valid ? span_pix.data : glyph_pix.data;
    end
  end

endmodule

`default_nettype wire

/* src/span_engine.sv */
`timescale 1ns/1ps
`default_nettype none
`include "draw_consts.svh"

// Strided run of same-color pixels: clear, lines, sample write.
module span_engine (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              go,
  input  wire draw_pkg::addr_t   base,
  input  wire draw_pkg::addr_t   step,
  input  wire logic [`ADDR_W-1:0] count,
  input  wire draw_pkg::pixel_t  color,
  output logic                   fin,
  pix_if.src                     pix
);

  draw_pkg::span_state_e state;
  draw_pkg::addr_t       addr;     // Address accumulator.
  logic [`ADDR_W-1:0]    remain;   // Pixels left, current one included.
  logic                  last;

  assign last = (remain == `ADDR_W'(1));

  // Request straight from state and accumulator.
  assign pix.valid = (state == draw_pkg::SP_ISSUE);
  assign pix.addr  = addr;
  assign pix.data  = color;       // Stable while the command runs.

  assign fin = pix.valid && pix.ack && last;   // Ack of the final pixel.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= draw_pkg::SP_IDLE;
      addr   <= '0;
      remain <= '0;
    end else begin
      case (state)
        draw_pkg::SP_IDLE: begin
          if (go) begin
            addr   <= base;
            remain <= count;
            state  <= draw_pkg::SP_ISSUE;
          end
        end
        draw_pkg::SP_ISSUE: begin
          if (pix.ack) begin
            if (last) begin
              state <= draw_pkg::SP_IDLE;           // Run complete.
            end else begin
              addr   <= addr + step;                // Next pixel.
              remain <= remain - 1'b1;
              state  <= draw_pkg::SP_WAIT;
            end
          end
        end
        draw_pkg::SP_WAIT: begin
          // Valid low one cycle so the writer never re-takes a pixel.
          state <= draw_pkg::SP_ISSUE;
        end
        default: state <= draw_pkg::SP_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/draw_pkg.sv
src/pix_if.sv
src/cmd_regs.sv
src/span_engine.sv
src/glyph_engine.sv
src/pixel_writer.sv
src/draw_core.sv
dv/draw_core_assert.sv
dv/draw_core_tb.sv
